// File: sources.f
source/glb_pkg.sv
source/glb_bank.sv
source/glb_tile_cfg.sv
source/glb_tile.sv
source/glb_dummy_start.sv
source/global_buffer.sv
testbench/tb_clock_gen.sv
testbench/global_buffer_chk.sv
testbench/tb_global_buffer.sv

// File: Makefile
SIM       = verilator
TOP       = tb_global_buffer
FILELIST  = sources.f
FLAGS     = --binary --timing --assert -j 0
OBJ_DIR   = obj_dir
LOG       = sim.log
RUN_ARGS  = +verilator+error+limit+1000
FAIL_MSG  = Checks failed
PASS_MSG  = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/tb_global_buffer.sv
// testbench for the global buffer with a reference memory and in-order read compares
`timescale 1ns/1ps

module tb_global_buffer;
    import glb_pkg::*;

    localparam int NUM_TILES       = 4;
    localparam int BANK_ADDR_WIDTH = 6;
    localparam int WORDS           = NUM_TILES << BANK_ADDR_WIDTH;
    // traffic and drains come to roughly 850 cycles
    localparam int MAX_CYCLES      = 3000;

    logic                       clk;
    logic                       reset;
    logic                       proc_wr_en;
    logic [BANK_STRB_WIDTH-1:0] proc_wr_strb;
    logic [GLB_ADDR_WIDTH-1:0]  proc_wr_addr;
    logic [BANK_DATA_WIDTH-1:0] proc_wr_data;
    logic                       proc_rd_en;
    logic [GLB_ADDR_WIDTH-1:0]  proc_rd_addr;
    logic [BANK_DATA_WIDTH-1:0] proc_rd_data;
    logic                       proc_rd_data_valid;
    logic                       cfg_wr_en;
    logic [CFG_ADDR_WIDTH-1:0]  cfg_wr_addr;
    logic [CFG_DATA_WIDTH-1:0]  cfg_wr_data;
    logic                       cfg_rd_en;
    logic [CFG_ADDR_WIDTH-1:0]  cfg_rd_addr;
    logic [CFG_DATA_WIDTH-1:0]  cfg_rd_data;
    logic                       cfg_rd_data_valid;

    // reference state and expected results in issue order
    logic [BANK_DATA_WIDTH-1:0] ref_mem [WORDS];
    logic [CFG_DATA_WIDTH-1:0]  ref_cfg [NUM_TILES*4];
    logic [BANK_DATA_WIDTH-1:0] proc_exp_q [$];
    logic [CFG_DATA_WIDTH-1:0]  cfg_exp_q [$];
    int                         seed = 32'hf310f5b3;
    int                         cycle_count = 0;

    tb_clock_gen #(
        .PERIOD_NS    (10),
        .RESET_CYCLES (10)
    ) u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    global_buffer #(
        .NUM_TILES       (NUM_TILES),
        .BANK_ADDR_WIDTH (BANK_ADDR_WIDTH)
    ) UUT (.*);

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] got);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] t=%0t %s expected %h got %h", $time, name, exp, got));
        end
    endtask

    // every request cycle starts from all enables low
    task automatic next_cycle();
        @(posedge clk);
        #1;
        proc_wr_en = 1'b0;
        proc_rd_en = 1'b0;
        cfg_wr_en  = 1'b0;
        cfg_rd_en  = 1'b0;
    endtask

    task automatic proc_write(input int addr, input logic [7:0] strb, input logic [63:0] data);
        next_cycle();
        proc_wr_en   = 1'b1;
        proc_wr_strb = strb;
        proc_wr_addr = 16'(addr);
        proc_wr_data = data;
        // locked tiles drop the write
        if (!ref_cfg[(addr >> BANK_ADDR_WIDTH) * 4][0]) begin
            for (int b = 0; b < 8; b++) begin
                if (strb[b]) begin
                    ref_mem[addr][b*8 +: 8] = data[b*8 +: 8];
                end
            end
        end
    endtask

    task automatic proc_read(input int addr);
        next_cycle();
        proc_rd_en   = 1'b1;
        proc_rd_addr = 16'(addr);
        if (addr < WORDS) begin
            proc_exp_q.push_back(ref_mem[addr]);
        end
    endtask

    task automatic cfg_write(input int addr, input logic [31:0] data);
        next_cycle();
        cfg_wr_en     = 1'b1;
        cfg_wr_addr   = 12'(addr);
        cfg_wr_data   = data;
        ref_cfg[addr] = data;
    endtask

    task automatic cfg_read(input int addr);
        next_cycle();
        cfg_rd_en   = 1'b1;
        cfg_rd_addr = 12'(addr);
        cfg_exp_q.push_back(ref_cfg[addr]);
    endtask

    // wait out all answers plus one full trip for stray valids
    task automatic drain();
        next_cycle();
        while (proc_exp_q.size() != 0 || cfg_exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2 * NUM_TILES + 4) @(posedge clk);
    endtask

    always @(negedge clk) begin
        if (!reset && proc_rd_data_valid) begin
            if (proc_exp_q.size() == 0) begin
                fail_run("proc_rd_data_valid rose with no read outstanding");
            end else begin
                check_value("proc_rd_data", proc_exp_q.pop_front(), proc_rd_data);
            end
        end
        if (!reset && cfg_rd_data_valid) begin
            if (cfg_exp_q.size() == 0) begin
                fail_run("cfg_rd_data_valid rose with no read outstanding");
            end else begin
                check_value("cfg_rd_data", 64'(cfg_exp_q.pop_front()), 64'(cfg_rd_data));
            end
        end
        if (UUT.u_chk.fail_count != 0) begin
            fail_run("an assertion in global_buffer_chk failed");
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            fail_run($sformatf("timeout, run still going after %0d cycles", MAX_CYCLES));
        end
    end

    initial begin
        logic [31:0] rnd;
        logic [31:0] cdata;
        int          addr;
        proc_wr_en   = 1'b0;
        proc_wr_strb = '0;
        proc_wr_addr = '0;
        proc_wr_data = '0;
        proc_rd_en   = 1'b0;
        proc_rd_addr = '0;
        cfg_wr_en    = 1'b0;
        cfg_wr_addr  = '0;
        cfg_wr_data  = '0;
        cfg_rd_en    = 1'b0;
        cfg_rd_addr  = '0;
        for (int i = 0; i < WORDS; i++) begin
            ref_mem[i] = '0;
        end
        for (int i = 0; i < NUM_TILES * 4; i++) begin
            ref_cfg[i] = '0;
        end
        @(negedge reset);

        // fill every tile with full strobes, then read all back in order
        for (int a = 0; a < WORDS; a++) begin
            proc_write(a, 8'hff, {$random(seed), $random(seed)});
        end
        for (int a = 0; a < WORDS; a++) begin
            proc_read(a);
        end
        drain();

        // partial strobes with each read issued on the very next cycle
        for (int i = 0; i < 32; i++) begin
            rnd  = $random(seed);
            addr = int'(rnd % 32'(WORDS));
            proc_write(addr, 8'($random(seed)), {$random(seed), $random(seed)});
            proc_read(addr);
        end
        drain();

        // all config registers with the lock bit kept clear
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int r = 0; r < 4; r++) begin
                cdata = $random(seed);
                if (r == 0) begin
                    cdata[0] = 1'b0;
                end
                cfg_write(t * 4 + r, cdata);
            end
        end
        for (int a = 0; a < NUM_TILES * 4; a++) begin
            cfg_read(a);
        end
        drain();

        // lock tile 2, write everywhere, then unlock and write again
        for (int pass = 0; pass < 2; pass++) begin
            cfg_write(2 * 4, (pass == 0) ? 32'h1 : 32'h0);
            cfg_read(2 * 4);
            drain();
            for (int t = 0; t < NUM_TILES; t++) begin
                for (int w = 0; w < 4; w++) begin
                    proc_write((t << BANK_ADDR_WIDTH) + w, 8'hff, {$random(seed), $random(seed)});
                end
            end
            for (int a = 0; a < NUM_TILES * 4; a++) begin
                proc_read(((a / 4) << BANK_ADDR_WIDTH) + a % 4);
            end
            drain();
        end

        // tile fields past the last tile get no answer
        proc_read(WORDS);
        proc_read(WORDS + 5);
        proc_read('hffff);
        drain();

        if (UUT.u_chk.fail_count != 0) begin
            fail_run("an assertion in global_buffer_chk failed");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

// File: testbench/global_buffer_chk.sv
// bound checks on read latency, stray valids and the reset state of the global buffer
`timescale 1ns/1ps

module global_buffer_chk #(
    parameter int NUM_TILES       = 4,
    parameter int BANK_ADDR_WIDTH = 6
) (
    input logic                                clk,
    input logic                                reset,
    input logic                                proc_rd_en,
    input logic [glb_pkg::GLB_ADDR_WIDTH-1:0]  proc_rd_addr,
    input logic [glb_pkg::BANK_DATA_WIDTH-1:0] proc_rd_data,
    input logic                                proc_rd_data_valid,
    input logic                                cfg_rd_en,
    input logic [glb_pkg::CFG_ADDR_WIDTH-1:0]  cfg_rd_addr,
    input logic [glb_pkg::CFG_DATA_WIDTH-1:0]  cfg_rd_data,
    input logic                                cfg_rd_data_valid
);

    localparam int PROC_LAT = 2 * NUM_TILES + 2;
    localparam int CFG_LAT  = NUM_TILES + 2;

    int   fail_count = 0;
    logic proc_rd_ok;
    logic cfg_rd_ok;

    // a read only answers when its tile field names a real tile
    assign proc_rd_ok = proc_rd_en && (int'(proc_rd_addr >> BANK_ADDR_WIDTH) < NUM_TILES);
    assign cfg_rd_ok  = cfg_rd_en && (int'(cfg_rd_addr >> 2) < NUM_TILES);

    a_reset_quiet: assert property (@(posedge clk)
        reset && $past(reset) |-> !proc_rd_data_valid && !cfg_rd_data_valid &&
            proc_rd_data == '0 && cfg_rd_data == '0)
    else begin
        $error("read outputs not low during reset");
        fail_count++;
    end

    // valid exactly PROC_LAT samples after an in-range read, never otherwise
    a_proc_latency: assert property (@(posedge clk) disable iff (reset)
        proc_rd_data_valid == $past(proc_rd_ok, PROC_LAT))
    else begin
        $error("proc_rd_data_valid does not match a read %0d cycles earlier", PROC_LAT);
        fail_count++;
    end

    a_cfg_latency: assert property (@(posedge clk) disable iff (reset)
        cfg_rd_data_valid == $past(cfg_rd_ok, CFG_LAT))
    else begin
        $error("cfg_rd_data_valid does not match a read %0d cycles earlier", CFG_LAT);
        fail_count++;
    end

endmodule

bind global_buffer global_buffer_chk #(
    .NUM_TILES       (NUM_TILES),
    .BANK_ADDR_WIDTH (BANK_ADDR_WIDTH)
) u_chk (
    .clk                (clk),
    .reset              (reset),
    .proc_rd_en         (proc_rd_en),
    .proc_rd_addr       (proc_rd_addr),
    .proc_rd_data       (proc_rd_data),
    .proc_rd_data_valid (proc_rd_data_valid),
    .cfg_rd_en          (cfg_rd_en),
    .cfg_rd_addr        (cfg_rd_addr),
    .cfg_rd_data        (cfg_rd_data),
    .cfg_rd_data_valid  (cfg_rd_data_valid)
);

// File: testbench/tb_clock_gen.sv
// clock and reset source for the global buffer testbench
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset drops just after a rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// File: source/global_buffer.sv
// global buffer top, start block feeding a chain of tiles that loops back west
`timescale 1ns/1ps

module global_buffer #(
    parameter int NUM_TILES       = 4,
    parameter int BANK_ADDR_WIDTH = 6
) (
    input  logic                                clk,
    input  logic                                reset,

    input  logic                                proc_wr_en,
    input  logic [glb_pkg::BANK_STRB_WIDTH-1:0] proc_wr_strb,
    input  logic [glb_pkg::GLB_ADDR_WIDTH-1:0]  proc_wr_addr,
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0] proc_wr_data,
    input  logic                                proc_rd_en,
    input  logic [glb_pkg::GLB_ADDR_WIDTH-1:0]  proc_rd_addr,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0] proc_rd_data,
    output logic                                proc_rd_data_valid,

    input  logic                                cfg_wr_en,
    input  logic [glb_pkg::CFG_ADDR_WIDTH-1:0]  cfg_wr_addr,
    input  logic [glb_pkg::CFG_DATA_WIDTH-1:0]  cfg_wr_data,
    input  logic                                cfg_rd_en,
    input  logic [glb_pkg::CFG_ADDR_WIDTH-1:0]  cfg_rd_addr,
    output logic [glb_pkg::CFG_DATA_WIDTH-1:0]  cfg_rd_data,
    output logic                                cfg_rd_data_valid
);
    import glb_pkg::*;

    // index k feeds tile k, last entry returns to the start block
    packet_t     proc_chain [NUM_TILES+1];
    cfg_packet_t cfg_chain  [NUM_TILES+1];

    glb_dummy_start u_dummy_start (
        .clk                (clk),
        .reset              (reset),
        .proc_wr_en         (proc_wr_en),
        .proc_wr_strb       (proc_wr_strb),
        .proc_wr_addr       (proc_wr_addr),
        .proc_wr_data       (proc_wr_data),
        .proc_rd_en         (proc_rd_en),
        .proc_rd_addr       (proc_rd_addr),
        .proc_rd_data       (proc_rd_data),
        .proc_rd_data_valid (proc_rd_data_valid),
        .cfg_wr_en          (cfg_wr_en),
        .cfg_wr_addr        (cfg_wr_addr),
        .cfg_wr_data        (cfg_wr_data),
        .cfg_rd_en          (cfg_rd_en),
        .cfg_rd_addr        (cfg_rd_addr),
        .cfg_rd_data        (cfg_rd_data),
        .cfg_rd_data_valid  (cfg_rd_data_valid),
        .proc_packet_esti   (proc_chain[NUM_TILES]),
        .proc_packet_esto   (proc_chain[0]),
        .cfg_packet_esti    (cfg_chain[NUM_TILES]),
        .cfg_packet_esto    (cfg_chain[0])
    );

    for (genvar k = 0; k < NUM_TILES; k++) begin : g_tile
        glb_tile #(
            .TILE_ID         (k),
            .BANK_ADDR_WIDTH (BANK_ADDR_WIDTH)
        ) u_tile (
            .clk              (clk),
            .reset            (reset),
            .proc_packet_wsti (proc_chain[k]),
            .proc_packet_esto (proc_chain[k+1]),
            .cfg_packet_wsti  (cfg_chain[k]),
            .cfg_packet_esto  (cfg_chain[k+1])
        );
    end

endmodule

// File: source/glb_dummy_start.sv
// west end of the tile chain, packs requests into packets and registers the responses
`timescale 1ns/1ps

module glb_dummy_start (
    input  logic                                clk,
    input  logic                                reset,

    // processor port
    input  logic                                proc_wr_en,
    input  logic [glb_pkg::BANK_STRB_WIDTH-1:0] proc_wr_strb,
    input  logic [glb_pkg::GLB_ADDR_WIDTH-1:0]  proc_wr_addr,
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0] proc_wr_data,
    input  logic                                proc_rd_en,
    input  logic [glb_pkg::GLB_ADDR_WIDTH-1:0]  proc_rd_addr,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0] proc_rd_data,
    output logic                                proc_rd_data_valid,

    // configuration port
    input  logic                                cfg_wr_en,
    input  logic [glb_pkg::CFG_ADDR_WIDTH-1:0]  cfg_wr_addr,
    input  logic [glb_pkg::CFG_DATA_WIDTH-1:0]  cfg_wr_data,
    input  logic                                cfg_rd_en,
    input  logic [glb_pkg::CFG_ADDR_WIDTH-1:0]  cfg_rd_addr,
    output logic [glb_pkg::CFG_DATA_WIDTH-1:0]  cfg_rd_data,
    output logic                                cfg_rd_data_valid,

    // packets to tile 0 and back from the last tile
    input  glb_pkg::packet_t                    proc_packet_esti,
    output glb_pkg::packet_t                    proc_packet_esto,
    input  glb_pkg::cfg_packet_t                cfg_packet_esti,
    output glb_pkg::cfg_packet_t                cfg_packet_esto
);
    import glb_pkg::*;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            proc_packet_esto   <= '0;
            cfg_packet_esto    <= '0;
            proc_rd_data       <= '0;
            proc_rd_data_valid <= 1'b0;
            cfg_rd_data        <= '0;
            cfg_rd_data_valid  <= 1'b0;
        end else begin
            // response slots leave empty, tiles fill them
            proc_packet_esto <= '{
                wr:   '{wr_en: proc_wr_en, wr_strb: proc_wr_strb,
                        wr_addr: proc_wr_addr, wr_data: proc_wr_data},
                rdrq: '{rd_en: proc_rd_en, rd_addr: proc_rd_addr},
                rdrs: '0
            };
            cfg_packet_esto <= '{
                wr_en: cfg_wr_en, wr_addr: cfg_wr_addr, wr_data: cfg_wr_data,
                rd_en: cfg_rd_en, rd_addr: cfg_rd_addr,
                rd_data: '0, rd_data_valid: 1'b0
            };

            // loop-back from the east end
            proc_rd_data       <= proc_packet_esti.rdrs.rd_data;
            proc_rd_data_valid <= proc_packet_esti.rdrs.rd_data_valid;
            cfg_rd_data        <= cfg_packet_esti.rd_data;
            cfg_rd_data_valid  <= cfg_packet_esti.rd_data_valid;
        end
    end

endmodule

// File: source/glb_tile.sv
// one buffer tile with its bank, config registers and the eastward packet pipeline
`timescale 1ns/1ps

module glb_tile #(
    parameter int TILE_ID         = 0,
    parameter int BANK_ADDR_WIDTH = 6
) (
    input  logic                 clk,
    input  logic                 reset,
    input  glb_pkg::packet_t     proc_packet_wsti,
    output glb_pkg::packet_t     proc_packet_esto,
    input  glb_pkg::cfg_packet_t cfg_packet_wsti,
    output glb_pkg::cfg_packet_t cfg_packet_esto
);
    import glb_pkg::*;

    localparam int PROC_TILE_W = GLB_ADDR_WIDTH - BANK_ADDR_WIDTH;
    localparam int CFG_TILE_W  = CFG_ADDR_WIDTH - 2;
    localparam logic [PROC_TILE_W-1:0] PROC_TILE_ID = PROC_TILE_W'(TILE_ID);
    localparam logic [CFG_TILE_W-1:0]  CFG_TILE_ID  = CFG_TILE_W'(TILE_ID);

    packet_t                    proc_stage1;
    logic                       wr_hit;
    logic                       rd_hit;
    logic                       rd_hit_s1;
    logic                       wr_lock;
    logic [BANK_DATA_WIDTH-1:0] bank_rd_data;
    logic                       cfg_wr_hit;
    logic                       cfg_rd_hit;
    logic [CFG_DATA_WIDTH-1:0]  cfg_rd_data;

    // tile field sits above the bank address
    assign wr_hit = proc_packet_wsti.wr.wr_en &&
        (proc_packet_wsti.wr.wr_addr[GLB_ADDR_WIDTH-1:BANK_ADDR_WIDTH] == PROC_TILE_ID);
    assign rd_hit = proc_packet_wsti.rdrq.rd_en &&
        (proc_packet_wsti.rdrq.rd_addr[GLB_ADDR_WIDTH-1:BANK_ADDR_WIDTH] == PROC_TILE_ID);
    assign rd_hit_s1 = proc_stage1.rdrq.rd_en &&
        (proc_stage1.rdrq.rd_addr[GLB_ADDR_WIDTH-1:BANK_ADDR_WIDTH] == PROC_TILE_ID);

    assign cfg_wr_hit = cfg_packet_wsti.wr_en &&
        (cfg_packet_wsti.wr_addr[CFG_ADDR_WIDTH-1:2] == CFG_TILE_ID);
    assign cfg_rd_hit = cfg_packet_wsti.rd_en &&
        (cfg_packet_wsti.rd_addr[CFG_ADDR_WIDTH-1:2] == CFG_TILE_ID);

    // bank access issued alongside stage one
    glb_bank #(
        .BANK_ADDR_WIDTH(BANK_ADDR_WIDTH)
    ) u_bank (
        .clk     (clk),
        .wr_en   (wr_hit && !wr_lock),
        .wr_strb (proc_packet_wsti.wr.wr_strb),
        .wr_addr (proc_packet_wsti.wr.wr_addr[BANK_ADDR_WIDTH-1:0]),
        .wr_data (proc_packet_wsti.wr.wr_data),
        .rd_en   (rd_hit),
        .rd_addr (proc_packet_wsti.rdrq.rd_addr[BANK_ADDR_WIDTH-1:0]),
        .rd_data (bank_rd_data)
    );

    glb_tile_cfg u_tile_cfg (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (cfg_wr_hit),
        .reg_sel (cfg_packet_wsti.wr_addr[1:0]),
        .wr_data (cfg_packet_wsti.wr_data),
        .rd_en   (cfg_rd_hit),
        .rd_sel  (cfg_packet_wsti.rd_addr[1:0]),
        .rd_data (cfg_rd_data),
        .wr_lock (wr_lock)
    );

    // two processor stages, read data joins in the second
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            proc_stage1      <= '0;
            proc_packet_esto <= '0;
        end else begin
            proc_stage1      <= proc_packet_wsti;
            proc_packet_esto <= proc_stage1;
            if (rd_hit_s1) begin
                proc_packet_esto.rdrs.rd_data       <= bank_rd_data;
                proc_packet_esto.rdrs.rd_data_valid <= 1'b1;
            end
        end
    end

    // config packets take a single stage
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_packet_esto <= '0;
        end else begin
            cfg_packet_esto <= cfg_packet_wsti;
            if (cfg_rd_hit) begin
                cfg_packet_esto.rd_data       <= cfg_rd_data;
                cfg_packet_esto.rd_data_valid <= 1'b1;
            end
        end
    end

endmodule

// File: source/glb_tile_cfg.sv
// per-tile configuration registers with read-back and the bank write lock
`timescale 1ns/1ps

module glb_tile_cfg (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               wr_en,
    input  logic [1:0]                         reg_sel,
    input  logic [glb_pkg::CFG_DATA_WIDTH-1:0] wr_data,
    input  logic                               rd_en,
    input  logic [1:0]                         rd_sel,
    output logic [glb_pkg::CFG_DATA_WIDTH-1:0] rd_data,
    output logic                               wr_lock
);
    import glb_pkg::*;

    localparam int NUM_REGS = 4;

    logic [CFG_DATA_WIDTH-1:0] cfg_reg [NUM_REGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                cfg_reg[i] <= '0;
            end
        end else if (wr_en) begin
            cfg_reg[reg_sel] <= wr_data;
        end
    end

    // read-back is combinational, tile merges it into the packet
    assign rd_data = rd_en ? cfg_reg[rd_sel] : '0;

    // reg 0 bit 0 blocks processor writes
    assign wr_lock = cfg_reg[0][0];

endmodule

// File: source/glb_bank.sv
// tile memory bank of 64-bit words with byte strobes and a registered read
`timescale 1ns/1ps

module glb_bank #(
    parameter int BANK_ADDR_WIDTH = 6
) (
    input  logic                                clk,
    input  logic                                wr_en,
    input  logic [glb_pkg::BANK_STRB_WIDTH-1:0] wr_strb,
    input  logic [BANK_ADDR_WIDTH-1:0]          wr_addr,
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0] wr_data,
    input  logic                                rd_en,
    input  logic [BANK_ADDR_WIDTH-1:0]          rd_addr,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0] rd_data
);
    import glb_pkg::*;

    localparam int DEPTH      = 1 << BANK_ADDR_WIDTH;
    localparam int BYTE_WIDTH = BANK_DATA_WIDTH / BANK_STRB_WIDTH;

    logic [BANK_DATA_WIDTH-1:0] mem [DEPTH];

    // one byte lane per strobe bit
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < BANK_STRB_WIDTH; b++) begin
                if (wr_strb[b]) begin
                    mem[wr_addr][b*BYTE_WIDTH +: BYTE_WIDTH] <=
                        wr_data[b*BYTE_WIDTH +: BYTE_WIDTH];
                end
            end
        end
    end

    // read data ready the cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: source/glb_pkg.sv
// global buffer package with bus widths and the packet structs of the tile chain
package glb_pkg;

    // processor side
    localparam int BANK_DATA_WIDTH = 64;
    localparam int BANK_STRB_WIDTH = BANK_DATA_WIDTH / 8;
    localparam int GLB_ADDR_WIDTH  = 16;

    // configuration side, low 2 address bits pick the register
    localparam int CFG_ADDR_WIDTH  = 12;
    localparam int CFG_DATA_WIDTH  = 32;

    typedef struct packed {
        logic                       wr_en;
        logic [BANK_STRB_WIDTH-1:0] wr_strb;
        logic [GLB_ADDR_WIDTH-1:0]  wr_addr;
        logic [BANK_DATA_WIDTH-1:0] wr_data;
    } wr_packet_t;

    typedef struct packed {
        logic                      rd_en;
        logic [GLB_ADDR_WIDTH-1:0] rd_addr;
    } rdrq_packet_t;

    typedef struct packed {
        logic [BANK_DATA_WIDTH-1:0] rd_data;
        logic                       rd_data_valid;
    } rdrs_packet_t;

    typedef struct packed {
        wr_packet_t   wr;
        rdrq_packet_t rdrq;
        rdrs_packet_t rdrs;
    } packet_t;

    typedef struct packed {
        logic                      wr_en;
        logic [CFG_ADDR_WIDTH-1:0] wr_addr;
        logic [CFG_DATA_WIDTH-1:0] wr_data;
        logic                      rd_en;
        logic [CFG_ADDR_WIDTH-1:0] rd_addr;
        logic [CFG_DATA_WIDTH-1:0] rd_data;
        logic                      rd_data_valid;
    } cfg_packet_t;

endpackage
